// File: Bender.yml
package:
  name: link_test

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - design/link_test_pkg.sv
  - design/link_test_regs.sv
  - design/mode_decoder.sv
  - design/lane_tester.sv
  - design/link_test_top.sv

  - target: test
    files:
      - verif/link_test_tb.sv

# Simulation top: link_test_tb
# Synthesis top: link_test_top

// File: design/lane_tester.sv
`timescale 1ns/1ps

module lane_tester import link_test_pkg::*; (
  input  logic       CLK,
  input  logic       RSTX,
  input  logic       enable,
  input  logic       hold,
  input  logic       clr,
  input  pattern_t   pattern,
  input  lane_data_t din,
  output lane_data_t dout,
  output lane_stat_t stat
);

  prbs_t      prbs;
  prbs_t      prbs_nxt;
  lane_data_t pat_nxt;
  lane_data_t bit_err;
  logic       restart;

  // One shift of the PRBS7 register
  function automatic prbs_t prbs_step(input prbs_t s);
    return {s[5:0], s[6] ^ s[5]};
  endfunction

  assign prbs_nxt = prbs_step(prbs_step(prbs)); // Two bits per cycle
  assign bit_err  = din ^ dout;
  assign restart  = !enable || clr;

  always_comb begin
    case (pattern)
      PAT_ALT:  pat_nxt = (dout == 2'b01) ? 2'b10 : 2'b01;
      PAT_CNT:  pat_nxt = dout + 2'd1;
      PAT_PRBS: pat_nxt = prbs_nxt[1:0];
      PAT_ZERO: pat_nxt = 2'b00;
    endcase
  end

  // Generator
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      dout <= '0;
      prbs <= PRBS_SEED;
    end else if (restart) begin
      dout <= '0;
      prbs <= PRBS_SEED;
    end else if (!hold) begin
      dout <= pat_nxt;
      if (pattern == PAT_PRBS) begin
        prbs <= prbs_nxt;
      end
    end
  end

  // Checker and counters
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      stat <= '0;
    end else if (restart) begin
      stat <= '0;
    end else if (!hold) begin
      stat.recv <= stat.recv + recv_cnt_t'(1);
      stat.err  <= stat.err + err_cnt_t'(bit_err[0]) + err_cnt_t'(bit_err[1]);
    end
  end

  a_err_step: assert property (
    @(posedge CLK) disable iff (!RSTX)
    (stat.err == '0) || (stat.err <= $past(stat.err) + err_cnt_t'(2))
  ) else $error("error count jumped by more than two bits");

endmodule

// File: design/link_test_pkg.sv
package link_test_pkg;

  localparam int NUM_LANES = 4;

  typedef logic [7:0]                   mode_t;
  typedef logic [1:0]                   lane_data_t;
  typedef logic [31:0]                  recv_cnt_t;
  typedef logic [31:0]                  err_cnt_t;
  typedef logic [NUM_LANES-1:0]         lane_mask_t;
  typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;
  typedef logic [1:0]                   pattern_t;
  typedef logic [15:0]                  dev_ctrl_t;
  typedef logic [6:0]                   prbs_t;
  typedef logic [2:0]                   wb_adr_t;
  typedef logic [31:0]                  wb_data_t;

  // Pattern codes
  localparam pattern_t PAT_ALT  = 2'd0;
  localparam pattern_t PAT_CNT  = 2'd1;
  localparam pattern_t PAT_PRBS = 2'd2; // PRBS7, x^7+x^6+1
  localparam pattern_t PAT_ZERO = 2'd3;

  localparam prbs_t PRBS_SEED = 7'h7f;

  // Main mode codes
  localparam mode_t MODE_IDLE   = 8'd0;
  localparam mode_t MODE_SINGLE = 8'd1;
  localparam mode_t MODE_ALL    = 8'd2;

  // Word addresses
  localparam wb_adr_t REG_MODE   = 3'd0;
  localparam wb_adr_t REG_CTRL   = 3'd1;
  localparam wb_adr_t REG_RECV   = 3'd2;
  localparam wb_adr_t REG_ERR    = 3'd3;
  localparam wb_adr_t REG_STATUS = 3'd4;

  localparam int CTRL_CLR_BIT  = 0;
  localparam int CTRL_HOLD_BIT = 1;

  localparam dev_ctrl_t DEV_CTRL_OFF = 16'h0001; // Link devices powered down

  typedef struct packed {
    lane_mask_t lane_en;
    pattern_t   pattern;
    lane_idx_t  rd_lane;
    dev_ctrl_t  dev_ctrl;
  } lane_cfg_t;

  typedef struct packed {
    recv_cnt_t recv;
    err_cnt_t  err;
  } lane_stat_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  localparam lane_cfg_t CFG_IDLE = '{lane_en: '0, pattern: PAT_ZERO, rd_lane: '0,
                                     dev_ctrl: DEV_CTRL_OFF};

endpackage

// File: design/link_test_regs.sv
`timescale 1ns/1ps

module link_test_regs import link_test_pkg::*; (
  input  logic       CLK,
  input  logic       RSTX,
  input  wb_req_t    wb_req,
  input  lane_cfg_t  cfg,
  input  lane_stat_t stats [NUM_LANES],
  output wb_data_t   wb_dat,
  output logic       wb_ack,
  output mode_t      main_mode,
  output mode_t      sub_mode,
  output logic       lane_clr,
  output logic       lane_hold
);

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_t;

  wb_state_t  state;
  wb_state_t  state_nxt;
  logic       req;
  logic       access;
  logic       wr_mode;
  logic       wr_ctrl;
  lane_stat_t sel_stat;
  pattern_t   stat_pat;

  assign req     = wb_req.cyc && wb_req.stb;
  assign access  = req && (state == WB_IDLE); // Accepted on this edge
  assign wr_mode = access && wb_req.we && (wb_req.adr == REG_MODE);
  assign wr_ctrl = access && wb_req.we && (wb_req.adr == REG_CTRL);

  always_comb begin
    state_nxt = state;
    case (state)
      WB_IDLE: if (req) state_nxt = WB_ACK;
      WB_ACK:  state_nxt = WB_IDLE; // Single-cycle ack
      default: state_nxt = WB_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      state <= WB_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign wb_ack = (state == WB_ACK);

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      main_mode <= MODE_IDLE;
      sub_mode  <= '0;
      lane_clr  <= 1'b0;
      lane_hold <= 1'b0;
    end else begin
      lane_clr <= wr_ctrl && wb_req.dat[CTRL_CLR_BIT]; // One-cycle pulse
      if (wr_mode) begin
        main_mode <= wb_req.dat[15:8];
        sub_mode  <= wb_req.dat[7:0];
      end
      if (wr_ctrl) begin
        lane_hold <= wb_req.dat[CTRL_HOLD_BIT];
      end
    end
  end

  assign sel_stat = stats[cfg.rd_lane];
  assign stat_pat = (cfg.lane_en != '0) ? cfg.pattern : '0; // Pattern shown for active link only

  // Address is held by the master through the ack cycle
  always_comb begin
    case (wb_req.adr)
      REG_MODE:   wb_dat = {16'd0, main_mode, sub_mode};
      REG_CTRL:   wb_dat = {30'd0, lane_hold, 1'b0};
      REG_RECV:   wb_dat = sel_stat.recv;
      REG_ERR:    wb_dat = sel_stat.err;
      REG_STATUS: wb_dat = {23'd0, lane_hold, 2'd0, stat_pat, cfg.lane_en};
      default:    wb_dat = '0;
    endcase
  end

  a_ack_single: assert property (
    @(posedge CLK) disable iff (!RSTX)
    wb_ack |=> !wb_ack
  ) else $error("wb_ack held for two cycles");

endmodule

// File: design/link_test_top.sv
`timescale 1ns/1ps

module link_test_top import link_test_pkg::*; (
  input  logic       CLK,
  input  logic       RSTX,
  input  wb_req_t    wb_req,
  input  lane_data_t lane_din [NUM_LANES],
  output wb_data_t   wb_dat,
  output logic       wb_ack,
  output lane_data_t lane_dout [NUM_LANES],
  output dev_ctrl_t  dev_ctrl
);

  mode_t      main_mode;
  mode_t      sub_mode;
  logic       lane_clr;
  logic       lane_hold;
  lane_cfg_t  cfg;
  lane_stat_t stats [NUM_LANES];

  link_test_regs i_regs (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .wb_req    (wb_req),
    .cfg       (cfg),
    .stats     (stats),
    .wb_dat    (wb_dat),
    .wb_ack    (wb_ack),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .lane_clr  (lane_clr),
    .lane_hold (lane_hold)
  );

  mode_decoder i_decoder (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .cfg       (cfg)
  );

  // One tester per lane, all sharing pattern and controls
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    lane_tester i_tester (
      .CLK     (CLK),
      .RSTX    (RSTX),
      .enable  (cfg.lane_en[k]),
      .hold    (lane_hold),
      .clr     (lane_clr),
      .pattern (cfg.pattern),
      .din     (lane_din[k]),
      .dout    (lane_dout[k]),
      .stat    (stats[k])
    );
  end

  assign dev_ctrl = cfg.dev_ctrl;

endmodule

// File: design/mode_decoder.sv
`timescale 1ns/1ps

module mode_decoder import link_test_pkg::*; (
  input  logic      CLK,
  input  logic      RSTX,
  input  mode_t     main_mode,
  input  mode_t     sub_mode,
  output lane_cfg_t cfg
);

  lane_cfg_t cfg_nxt;

  // Control word for the external link devices
  function automatic dev_ctrl_t dev_word(input lane_mask_t en, input pattern_t pat);
    dev_ctrl_t w;
    w = '0;
    if (en == '0) begin
      w = DEV_CTRL_OFF;
    end else begin
      w[5:2] = en;
      w[7:6] = pat;
    end
    return w;
  endfunction

  always_comb begin
    cfg_nxt = CFG_IDLE;
    case (main_mode)
      MODE_IDLE: begin
        cfg_nxt = CFG_IDLE;
      end
      MODE_SINGLE: begin
        cfg_nxt.lane_en = lane_mask_t'(1) << sub_mode[1:0]; // One-hot lane
        cfg_nxt.pattern = sub_mode[3:2];
        cfg_nxt.rd_lane = sub_mode[1:0];
      end
      MODE_ALL: begin
        cfg_nxt.lane_en = '1;
        cfg_nxt.pattern = sub_mode[3:2];
        cfg_nxt.rd_lane = sub_mode[1:0];
      end
      default: begin
        cfg_nxt = CFG_IDLE; // Unknown codes park the link
      end
    endcase
    cfg_nxt.dev_ctrl = dev_word(cfg_nxt.lane_en, cfg_nxt.pattern);
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      cfg <= CFG_IDLE;
    end else begin
      cfg <= cfg_nxt;
    end
  end

  a_off_bit: assert property (
    @(posedge CLK) disable iff (!RSTX)
    cfg.dev_ctrl[0] == (cfg.lane_en == '0)
  ) else $error("dev_ctrl off bit disagrees with lane mask");

endmodule

// File: project.f
design/link_test_pkg.sv
design/link_test_regs.sv
design/mode_decoder.sv
design/lane_tester.sv
design/link_test_top.sv
verif/link_test_tb.sv

// File: verif/link_test_tb.sv
`timescale 1ns/1ps

module link_test_tb import link_test_pkg::*; ();

  localparam int          CLK_PERIOD      = 8;
  localparam int          NUM_TESTS       = 5;
  localparam int          CYCLES_PER_TEST = 2000;
  localparam int          ACK_LIMIT       = 16;
  localparam logic [31:0] LFSR_SEED       = 32'h4dfd43eb;
  localparam logic [31:0] LFSR_TAPS       = 32'h80200003;

  logic       CLK;
  logic       RSTX;
  wb_req_t    wb_req;
  wb_data_t   wb_dat;
  logic       wb_ack;
  lane_data_t lane_din [NUM_LANES];
  lane_data_t lane_dout [NUM_LANES];
  dev_ctrl_t  dev_ctrl;

  lane_data_t  inj [NUM_LANES];
  logic        inject_on;
  logic [31:0] lfsr;

  mode_t      sh_main;  // Register contents as written over the bus
  mode_t      sh_sub;
  logic       sh_hold;
  logic       clr_flag;
  lane_mask_t m_en;     // Decoder output as seen by the testers
  pattern_t   m_pat;
  lane_data_t m_dout [NUM_LANES];
  prbs_t      m_prbs [NUM_LANES];
  recv_cnt_t  m_recv [NUM_LANES];
  err_cnt_t   m_err [NUM_LANES];
  int         errors;
  int         checks;

  link_test_top dut_i (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .wb_req    (wb_req),
    .lane_din  (lane_din),
    .wb_dat    (wb_dat),
    .wb_ack    (wb_ack),
    .lane_dout (lane_dout),
    .dev_ctrl  (dev_ctrl)
  );

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_din[k] = lane_dout[k] ^ inj[k]; // Loopback with error injection
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // Next pattern value, with the PRBS7 state in the upper bits
  function automatic logic [8:0] ref_next(input pattern_t pat, input lane_data_t cur,
                                          input prbs_t pr);
    prbs_t      s;
    lane_data_t v;
    s = pr;
    v = 2'b00;
    case (pat)
      PAT_ALT:  v = (cur == 2'b01) ? 2'b10 : 2'b01;
      PAT_CNT:  v = cur + 2'd1;
      PAT_PRBS: begin
        for (int i = 0; i < 2; i++) begin
          s = {s[5:0], s[6] ^ s[5]}; // x^7 + x^6 + 1
        end
        v = s[1:0];
      end
      default:  v = 2'b00;
    endcase
    return {s, v};
  endfunction

  function automatic lane_mask_t mask_for(input mode_t main, input mode_t sub);
    if (main == MODE_SINGLE) return lane_mask_t'(1) << sub[1:0];
    if (main == MODE_ALL) return 4'hf;
    return 4'h0;
  endfunction

  function automatic pattern_t pat_for(input mode_t main, input mode_t sub);
    return (main == MODE_SINGLE || main == MODE_ALL) ? sub[3:2] : PAT_ZERO;
  endfunction

  function automatic dev_ctrl_t exp_dev_ctrl(input lane_mask_t mask, input pattern_t pat);
    if (mask == '0) return 16'h0001;
    return {8'h00, pat, mask, 2'b00};
  endfunction

  function automatic wb_data_t exp_status(input lane_mask_t mask, input pattern_t pat,
                                          input logic hold);
    wb_data_t s;
    s = '0;
    s[3:0] = mask;
    if (mask != '0) s[5:4] = pat; // Pattern field reads 0 with no lane active
    s[8] = hold;
    return s;
  endfunction

  function automatic wb_data_t mode_word(input mode_t main, input pattern_t pat, input int lane);
    return {16'h0000, main, 4'h0, pat, lane[1:0]};
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
    int n;
    n = 0;
    @(negedge CLK);
    wb_req = {1'b1, 1'b1, 1'b1, adr, dat};
    @(negedge CLK);
    while (!wb_ack && n < ACK_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (!wb_ack) begin
      errors++;
      $display("Wishbone write to address %0d got no ack", adr);
    end
    wb_req = '0;
    if (adr == REG_MODE) begin
      sh_main = dat[15:8];
      sh_sub  = dat[7:0];
    end
    if (adr == REG_CTRL) begin
      sh_hold  = dat[CTRL_HOLD_BIT];
      clr_flag = dat[CTRL_CLR_BIT];
    end
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
    int n;
    n = 0;
    @(negedge CLK);
    wb_req = {1'b1, 1'b1, 1'b0, adr, 32'h0};
    @(negedge CLK);
    while (!wb_ack && n < ACK_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (!wb_ack) begin
      errors++;
      $display("Wishbone read from address %0d got no ack", adr);
    end
    dat = wb_dat;
    wb_req = '0;
  endtask

  // Steps rd_lane over all lanes, pattern left unchanged
  task automatic read_counts();
    wb_data_t rd;
    for (int k = 0; k < NUM_LANES; k++) begin
      wb_write(REG_MODE, mode_word(MODE_ALL, PAT_PRBS, k));
      wait_cycles(2);
      wb_read(REG_RECV, rd);
      check_word("REG_RECV", rd, m_recv[k]);
      wb_read(REG_ERR, rd);
      check_word("REG_ERR", rd, m_err[k]);
    end
  endtask

  task automatic report_test(input string name, input int base);
    if (errors == base) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - base);
  endtask

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    lfsr = LFSR_SEED;
    for (int k = 0; k < NUM_LANES; k++) inj[k] = 2'b00;
    forever begin
      @(negedge CLK);
      for (int k = 0; k < NUM_LANES; k++) begin
        for (int b = 0; b < 2; b++) begin
          inj[k][b] = inject_on & lfsr[0];
          if (inject_on) lfsr = lfsr_next(lfsr); // One step per bit taken
        end
      end
    end
  end

  // Pre-edge values; the DUT registers update after this process runs
  always @(posedge CLK) begin : compare
    logic [8:0] nxt;
    if (!RSTX) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        m_dout[k] = 2'b00;
        m_prbs[k] = 7'h7f;
        m_recv[k] = '0;
        m_err[k]  = '0;
      end
      m_en  = '0;
      m_pat = PAT_ZERO;
    end else begin
      for (int k = 0; k < NUM_LANES; k++) begin
        checks++;
        if (lane_dout[k] !== m_dout[k]) begin
          errors++;
          $display("Mismatch at %0t: lane %0d dout %b, expected %b",
                   $time, k, lane_dout[k], m_dout[k]);
        end
        if (!m_en[k] || clr_flag) begin
          m_dout[k] = 2'b00;
          m_prbs[k] = 7'h7f;
          m_recv[k] = '0;
          m_err[k]  = '0;
        end else if (!sh_hold) begin
          m_recv[k] = m_recv[k] + 1;
          m_err[k]  = m_err[k] + (lane_din[k][0] ^ lane_dout[k][0])
                               + (lane_din[k][1] ^ lane_dout[k][1]);
          nxt = ref_next(m_pat, m_dout[k], m_prbs[k]);
          m_dout[k] = nxt[1:0];
          m_prbs[k] = nxt[8:2];
        end
      end
      clr_flag = 1'b0;
      m_en  = mask_for(sh_main, sh_sub); // Decoder registers on this edge
      m_pat = pat_for(sh_main, sh_sub);
    end
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    wb_data_t rd;
    int       base;
    RSTX      = 1'b0;
    wb_req    = '0;
    inject_on = 1'b0;
    sh_main   = MODE_IDLE;
    sh_sub    = '0;
    sh_hold   = 1'b0;
    clr_flag  = 1'b0;
    errors    = 0;
    checks    = 0;
    repeat (2) @(negedge CLK);
    RSTX = 1'b1;

    base = errors;
    check_word("dev_ctrl", dev_ctrl, 32'h1);
    for (int k = 0; k < NUM_LANES; k++) check_word("lane_dout", lane_dout[k], 32'h0);
    wb_read(REG_RECV, rd);
    check_word("REG_RECV", rd, 32'h0);
    wb_read(REG_ERR, rd);
    check_word("REG_ERR", rd, 32'h0);
    wb_read(REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h0);
    report_test("reset values", base);

    base = errors;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      for (int p = PAT_ALT; p <= PAT_PRBS; p++) begin
        wb_write(REG_MODE, mode_word(MODE_SINGLE, p[1:0], lane));
        wait_cycles(3);
        check_word("dev_ctrl", dev_ctrl, exp_dev_ctrl(4'b0001 << lane, p[1:0]));
        wb_read(REG_STATUS, rd);
        check_word("REG_STATUS", rd, exp_status(4'b0001 << lane, p[1:0], 1'b0));
        wait_cycles(40);
      end
    end
    report_test("single lane patterns", base);

    base = errors;
    wb_write(REG_MODE, mode_word(MODE_ALL, PAT_PRBS, 0));
    inject_on = 1'b1;
    wait_cycles(200);
    inject_on = 1'b0;
    check_word("dev_ctrl", dev_ctrl, exp_dev_ctrl(4'hf, PAT_PRBS));
    wb_write(REG_CTRL, 32'h2); // Freeze counters
    wait_cycles(2);
    wb_read(REG_STATUS, rd);
    check_word("REG_STATUS", rd, exp_status(4'hf, PAT_PRBS, 1'b1));
    if (m_err[0] == '0) begin
      errors++;
      $display("No bit errors were injected on lane 0");
    end
    read_counts();
    report_test("all lanes with injection", base);

    base = errors;
    wb_write(REG_CTRL, 32'h0);
    inject_on = 1'b1;
    wait_cycles(50);
    wb_write(REG_CTRL, 32'h1); // Clear pulse, hold released
    wait_cycles(60);
    inject_on = 1'b0;
    wb_write(REG_CTRL, 32'h2);
    wait_cycles(2);
    for (int k = 0; k < NUM_LANES; k++) begin
      if (m_recv[k] > 80 || m_recv[k] == '0) begin
        errors++;
        $display("Lane %0d receive count %0d does not follow the clear", k, m_recv[k]);
      end
    end
    read_counts();
    report_test("clear while running", base);

    base = errors;
    wb_write(REG_CTRL, 32'h0);
    wb_write(REG_MODE, mode_word(MODE_IDLE, PAT_ALT, 0));
    wait_cycles(3);
    check_word("dev_ctrl", dev_ctrl, 32'h1);
    wb_read(REG_RECV, rd);
    check_word("REG_RECV", rd, 32'h0);
    wb_read(REG_ERR, rd);
    check_word("REG_ERR", rd, 32'h0);
    wb_read(REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h0);
    wb_write(REG_MODE, {16'h0000, 8'h7c, 8'h09}); // Undefined main mode
    wait_cycles(3);
    check_word("dev_ctrl", dev_ctrl, 32'h1);
    wb_read(REG_MODE, rd);
    check_word("REG_MODE", rd, {16'h0000, 8'h7c, 8'h09});
    wb_read(REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h0);
    wb_read(REG_RECV, rd);
    check_word("REG_RECV", rd, 32'h0);
    for (int k = 0; k < NUM_LANES; k++) check_word("lane_dout", lane_dout[k], 32'h0);
    report_test("idle and undefined mode", base);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
